//--- src/zx_mem_pkg.sv
`default_nettype none

package zx_mem_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int PAGE_W  = 8;
	localparam int ZADDR_W = 16;
	localparam int ZDATA_W = 8;
	localparam int DADDR_W = 21;
	localparam int DWORD_W = 16;
	localparam int BSEL_W  = 2;
	localparam int NUM_WIN = 4;

	typedef logic [PAGE_W-1:0]  page_t;
	typedef logic [ZADDR_W-1:0] zaddr_t;
	typedef logic [ZDATA_W-1:0] zdata_t;
	typedef logic [DADDR_W-1:0] daddr_t;
	typedef logic [DWORD_W-1:0] dword_t;

	// bit 1 high byte, bit 0 low byte
	typedef logic [BSEL_W-1:0]  bsel_t;

	typedef enum logic [1:0] {PH_C0, PH_C1, PH_C2, PH_C3} phase_e;

	typedef enum logic [1:0] {OWN_NONE, OWN_VIDEO, OWN_CPU} owner_e;

	////////////////////////////////////////
	// bus and command bundles
	////////////////////////////////////////

	typedef struct packed {
		zaddr_t za;
		zdata_t zd;
		logic   rnw;
	} z80_bus_t;

	typedef struct packed {
		daddr_t addr;
		logic   rnw;
		bsel_t  bsel;
		dword_t wrdata;
	} dram_cmd_t;

endpackage

`default_nettype wire

//--- src/phase_counter.sv
`timescale 1ns/1ps
`default_nettype none

module phase_counter
	import zx_mem_pkg::*;
(
	input  wire logic fclk,
	input  wire logic rst_n,
	output phase_e    phase
);

	// four fclk cycles per DRAM slot, c0 first
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= PH_C0;
		end
		else
		begin
			phase <= phase_e'(phase + 2'd1);
		end
	end

endmodule

`default_nettype wire

//--- src/window_pager.sv
`timescale 1ns/1ps
`default_nettype none

module window_pager
	import zx_mem_pkg::*;
(
	input  wire logic     fclk,
	input  wire logic     rst_n,
	input  z80_bus_t      cpu_bus,
	input  wire logic     page_wr,
	output dram_cmd_t     cpu_cmd
);

	page_t        page_q [NUM_WIN];
	logic [1:0]   win;

	// window index comes from the two top address bits
	assign win = cpu_bus.za[15:14];

	////////////////////////////////////////
	// page registers
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_WIN; i++)
			begin
				page_q[i] <= page_t'(i);
			end
		end
		else if (page_wr)
		begin
			page_q[win] <= cpu_bus.zd;
		end
	end

	////////////////////////////////////////
	// address translation
	////////////////////////////////////////

	always_comb
	begin
		cpu_cmd.addr   = {page_q[win], cpu_bus.za[13:1]};
		cpu_cmd.rnw    = cpu_bus.rnw;
		// odd address selects the high lane
		cpu_cmd.bsel   = cpu_bus.za[0] ? 2'b10 : 2'b01;
		cpu_cmd.wrdata = {cpu_bus.zd, cpu_bus.zd};
	end

endmodule

`default_nettype wire

//--- src/cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_port
	import zx_mem_pkg::*;
(
	input  wire logic fclk,
	input  wire logic rst_n,
	input  phase_e    phase,
	input  wire logic cpu_req,
	input  dram_cmd_t cpu_cmd,
	input  wire logic cpu_next,
	input  dword_t    dram_rddata,
	output logic      cpu_pend,
	output dram_cmd_t pend_cmd,
	output logic      cpu_busy,
	output logic      cpu_done,
	output zdata_t    cpu_rddata
);

	logic accept;
	logic req_q;
	logic slot_act;
	logic sample;

	// a second request during a busy access is dropped
	assign accept = cpu_req && !cpu_busy;

	// data phase of our own slot
	assign sample = slot_act && (phase == PH_C2);

	////////////////////////////////////////
	// request and slot tracking
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_q    <= 1'b0;
			cpu_pend <= 1'b0;
			slot_act <= 1'b0;
			cpu_busy <= 1'b0;
			cpu_done <= 1'b0;
		end
		else
		begin
			req_q    <= accept;
			cpu_done <= sample;
			// pending follows the captured command by one cycle
			if (req_q)
				cpu_pend <= 1'b1;
			else if (cpu_next)
				cpu_pend <= 1'b0;
			if (cpu_next)
				slot_act <= 1'b1;
			else if (sample)
				slot_act <= 1'b0;
			if (accept)
				cpu_busy <= 1'b1;
			else if (sample)
				cpu_busy <= 1'b0;
		end
	end

	// held command and read byte
	always_ff @(posedge fclk)
	begin
		if (accept)
			pend_cmd <= cpu_cmd;
		if (sample && pend_cmd.rnw)
			cpu_rddata <= pend_cmd.bsel[1] ? dram_rddata[15:8] : dram_rddata[7:0];
	end

endmodule

`default_nettype wire

//--- src/dram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dram_arbiter
	import zx_mem_pkg::*;
#(
	parameter bit VIDEO_FIRST = 1'b1
)
(
	input  wire logic fclk,
	input  wire logic rst_n,
	input  phase_e    phase,
	input  wire logic video_req,
	input  daddr_t    video_addr,
	input  wire logic cpu_pend,
	input  dram_cmd_t pend_cmd,
	output logic      cpu_next,
	output logic      dram_req,
	output dram_cmd_t dram_cmd
);

	owner_e    owner;
	owner_e    next_owner;
	logic      pend_q;
	dram_cmd_t video_cmd;

	////////////////////////////////////////
	// slot owner
	////////////////////////////////////////

	// registered view of the cpu request
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend_q <= 1'b0;
		end
		else
		begin
			pend_q <= cpu_pend;
		end
	end

	always_comb
	begin
		if (video_req && VIDEO_FIRST)
			next_owner = OWN_VIDEO;
		else if (pend_q)
			next_owner = OWN_CPU;
		else if (video_req)
			next_owner = OWN_VIDEO;
		else
			next_owner = OWN_NONE;
	end

	// decision at c3, owner holds for the whole next slot
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			owner <= OWN_NONE;
		end
		else if (phase == PH_C3)
		begin
			owner <= next_owner;
		end
	end

	////////////////////////////////////////
	// command issue
	////////////////////////////////////////

	always_comb
	begin
		video_cmd.addr   = video_addr;
		video_cmd.rnw    = 1'b1;
		video_cmd.bsel   = 2'b11;
		video_cmd.wrdata = '0;
	end

	assign dram_req = (phase == PH_C0) && (owner != OWN_NONE);
	assign cpu_next = (phase == PH_C0) && (owner == OWN_CPU);

	// only meaningful while dram_req is high
	assign dram_cmd = (owner == OWN_VIDEO) ? video_cmd : pend_cmd;

endmodule

`default_nettype wire

//--- src/zx_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_mem_top
	import zx_mem_pkg::*;
#(
	parameter bit VIDEO_FIRST = 1'b1
)
(
	input  wire logic fclk,
	input  wire logic rst_n,

	// cpu side
	input  z80_bus_t  cpu_bus,
	input  wire logic cpu_req,
	input  wire logic page_wr,
	output logic      cpu_busy,
	output logic      cpu_done,
	output zdata_t    cpu_rddata,

	// video fetcher
	input  wire logic video_req,
	input  daddr_t    video_addr,

	// dram
	output logic      dram_req,
	output dram_cmd_t dram_cmd,
	input  dword_t    dram_rddata
);

	phase_e    phase;
	dram_cmd_t cpu_cmd;
	dram_cmd_t pend_cmd;
	logic      cpu_pend;
	logic      cpu_next;

	phase_counter i_phase_counter (
		.fclk  (fclk),
		.rst_n (rst_n),
		.phase (phase)
	);

	window_pager i_window_pager (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.cpu_bus (cpu_bus),
		.page_wr (page_wr),
		.cpu_cmd (cpu_cmd)
	);

	cpu_port i_cpu_port (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.phase       (phase),
		.cpu_req     (cpu_req),
		.cpu_cmd     (cpu_cmd),
		.cpu_next    (cpu_next),
		.dram_rddata (dram_rddata),
		.cpu_pend    (cpu_pend),
		.pend_cmd    (pend_cmd),
		.cpu_busy    (cpu_busy),
		.cpu_done    (cpu_done),
		.cpu_rddata  (cpu_rddata)
	);

	dram_arbiter #(
		.VIDEO_FIRST (VIDEO_FIRST)
	) i_dram_arbiter (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.phase      (phase),
		.video_req  (video_req),
		.video_addr (video_addr),
		.cpu_pend   (cpu_pend),
		.pend_cmd   (pend_cmd),
		.cpu_next   (cpu_next),
		.dram_req   (dram_req),
		.dram_cmd   (dram_cmd)
	);

endmodule

`default_nettype wire

//--- test/zx_mem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module zx_mem_sva
	import zx_mem_pkg::*;
(
	input wire logic   fclk,
	input wire logic   rst_n,
	input wire phase_e phase,
	input wire logic   dram_req,
	input wire logic   cpu_next
);

	// a slot opens only in its first phase
	a_req_at_c0 : assert property (@(posedge fclk) disable iff (!rst_n)
		dram_req |-> (phase == PH_C0))
		else $error("dram_req outside phase c0");

	a_next_with_req : assert property (@(posedge fclk) disable iff (!rst_n)
		cpu_next |-> dram_req)
		else $error("cpu_next without dram_req");

	// one command per slot
	a_req_single : assert property (@(posedge fclk) disable iff (!rst_n)
		dram_req |=> !dram_req)
		else $error("dram_req high in two consecutive cycles");

endmodule

bind dram_arbiter zx_mem_sva i_zx_mem_sva (
	.fclk     (fclk),
	.rst_n    (rst_n),
	.phase    (phase),
	.dram_req (dram_req),
	.cpu_next (cpu_next)
);

`default_nettype wire

//--- test/tb_zx_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_mem_top
	import zx_mem_pkg::*;
();

	localparam int     CLK_PERIOD     = 100;
	localparam int     DRIVE_DLY      = 5;
	localparam int     RESET_CYCLES   = 10;
	localparam int     NUM_ROWS       = 9;
	localparam int     ROW_CYCLES     = 40;
	localparam int     TIMEOUT_CYCLES = NUM_ROWS * ROW_CYCLES + RESET_CYCLES;
	localparam int     SLOT_CYCLES    = 4;
	localparam int     VIDEO_SLOTS    = 3;
	localparam int     MIN_LATENCY    = 7;
	localparam int     MAX_LATENCY    = 10;
	localparam int     MEM_AW         = 17;
	localparam daddr_t VIDEO_ADDR     = 21'h00_1a2c;

	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_PAGE} op_e;

	typedef struct packed {
		op_e    op;
		zaddr_t za;
		zdata_t zd;
		logic   video;
		daddr_t exp_addr;
		dword_t exp_word;
		zdata_t exp_byte;
	} row_t;

	logic      fclk;
	logic      rst_n;
	z80_bus_t  cpu_bus;
	logic      cpu_req;
	logic      page_wr;
	logic      video_req;
	daddr_t    video_addr;
	dword_t    dram_rddata;
	logic      cpu_busy;
	logic      cpu_done;
	zdata_t    cpu_rddata;
	logic      dram_req;
	dram_cmd_t dram_cmd;

	dword_t            mem    [1 << MEM_AW];
	dword_t            mirror [1 << MEM_AW];
	logic [MEM_AW-1:0] rec_idx;
	row_t              tests  [NUM_ROWS];
	int                errors    = 0;
	int                cycle_cnt = 0;

	zx_mem_top #(
		.VIDEO_FIRST (1'b1)
	) i_zx_mem_top (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.cpu_bus     (cpu_bus),
		.cpu_req     (cpu_req),
		.page_wr     (page_wr),
		.cpu_busy    (cpu_busy),
		.cpu_done    (cpu_done),
		.cpu_rddata  (cpu_rddata),
		.video_req   (video_req),
		.video_addr  (video_addr),
		.dram_req    (dram_req),
		.dram_cmd    (dram_cmd),
		.dram_rddata (dram_rddata)
	);

	initial
	begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	always @(posedge fclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("run stopped after %0d cycles without finishing", cycle_cnt);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// dram model
	////////////////////////////////////////

	always @(posedge fclk)
	begin
		if (dram_req)
		begin
			rec_idx <= dram_cmd.addr[MEM_AW-1:0];
			if (!dram_cmd.rnw && dram_cmd.bsel[1])
				mem[dram_cmd.addr[MEM_AW-1:0]][15:8] = dram_cmd.wrdata[15:8];
			if (!dram_cmd.rnw && dram_cmd.bsel[0])
				mem[dram_cmd.addr[MEM_AW-1:0]][7:0] = dram_cmd.wrdata[7:0];
		end
	end

	assign dram_rddata = mem[rec_idx];

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic step_cycle();
		@(posedge fclk);
		#DRIVE_DLY;
	endtask

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic row_t make_row(op_e op, zaddr_t za, zdata_t zd, logic video);
		row_t r;
		r = '{op, za, zd, video, '0, '0, '0};
		return r;
	endfunction

	function automatic string op_label(op_e op);
		if (op == OP_PAGE)
			return "page ";
		else if (op == OP_WRITE)
			return "write";
		return "read ";
	endfunction

	// walk the table with its own copy of the pages and the memory
	task automatic build_expected();
		page_t             pmir [NUM_WIN];
		daddr_t            a;
		logic [MEM_AW-1:0] idx;
		zdata_t            last_rd;
		last_rd = '0;
		for (int w = 0; w < NUM_WIN; w++)
			pmir[w] = page_t'(w);
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			a   = {pmir[tests[i].za[15:14]], tests[i].za[13:1]};
			idx = a[MEM_AW-1:0];
			tests[i].exp_addr = a;
			case (tests[i].op)
				OP_PAGE:  pmir[tests[i].za[15:14]] = tests[i].zd;
				OP_WRITE:
				begin
					if (tests[i].za[0])
						mirror[idx][15:8] = tests[i].zd;
					else
						mirror[idx][7:0] = tests[i].zd;
				end
				default: ;
			endcase
			tests[i].exp_word = mirror[idx];
			// a write keeps the byte of the last read
			if (tests[i].op == OP_READ)
			begin
				tests[i].exp_byte = tests[i].za[0] ? mirror[idx][15:8] : mirror[idx][7:0];
				last_rd           = tests[i].exp_byte;
			end
			else
				tests[i].exp_byte = last_rd;
		end
	endtask

	task automatic run_page(input row_t r);
		cpu_bus = '{za: r.za, zd: r.zd, rnw: 1'b1};
		page_wr = 1'b1;
		step_cycle();
		page_wr = 1'b0;
		step_cycle();
	endtask

	task automatic run_access(input row_t r);
		logic holding;
		int   cycles;
		int   waited;
		int   limit;
		int   video_cmds;
		int   cpu_cmds;
		cycles     = 0;
		waited     = 0;
		video_cmds = 0;
		cpu_cmds   = 0;
		holding    = r.video;
		limit      = r.video ? ROW_CYCLES : MAX_LATENCY;
		cpu_bus    = '{za: r.za, zd: r.zd, rnw: (r.op == OP_READ)};
		cpu_req    = 1'b1;
		video_req  = r.video;
		while (!cpu_done && waited < limit)
		begin
			step_cycle();
			cpu_req = 1'b0;
			cycles++;
			waited++;
			if (holding)
			begin
				if (!cpu_busy)
					report_mismatch("cpu_busy low while video holds the slots");
				if (dram_req)
				begin
					if (dram_cmd.addr != video_addr || !dram_cmd.rnw || dram_cmd.bsel != 2'b11)
						report_mismatch("slot under video priority is not the video read");
					video_cmds++;
				end
				// release video so the cpu gets the next slot
				if (video_cmds == VIDEO_SLOTS)
				begin
					video_req = 1'b0;
					holding   = 1'b0;
					waited    = 0;
					limit     = VIDEO_SLOTS * SLOT_CYCLES;
				end
			end
			else if (dram_req)
			begin
				cpu_cmds++;
				if (dram_cmd.addr != r.exp_addr)
					report_mismatch($sformatf("dram addr %h, expected %h",
						dram_cmd.addr, r.exp_addr));
				if (dram_cmd.rnw != (r.op == OP_READ) ||
					dram_cmd.bsel != (r.za[0] ? 2'b10 : 2'b01))
					report_mismatch($sformatf("dram rnw %b bsel %b for za %h",
						dram_cmd.rnw, dram_cmd.bsel, r.za));
				if (r.op == OP_WRITE && dram_cmd.wrdata != {r.zd, r.zd})
					report_mismatch($sformatf("dram wrdata %h", dram_cmd.wrdata));
			end
		end
		video_req = 1'b0;
		if (!cpu_done)
			report_problem($sformatf("no cpu_done within %0d cycles", limit));
		else
		begin
			if (holding)
				report_mismatch("cpu_done before video released the slots");
			if (!r.video && (cycles < MIN_LATENCY || cycles > MAX_LATENCY))
				report_mismatch($sformatf("latency %0d cycles", cycles));
			if (cpu_cmds != 1)
				report_mismatch($sformatf("%0d cpu dram commands", cpu_cmds));
			if (cpu_busy)
				report_mismatch("cpu_busy still high with cpu_done");
			if (cpu_rddata != r.exp_byte)
				report_mismatch($sformatf("cpu_rddata %h, expected %h",
					cpu_rddata, r.exp_byte));
			if (r.op == OP_WRITE && mem[r.exp_addr[MEM_AW-1:0]] != r.exp_word)
				report_mismatch($sformatf("dram word %h, expected %h",
					mem[r.exp_addr[MEM_AW-1:0]], r.exp_word));
		end
		step_cycle();
		if (cpu_done)
			report_mismatch("cpu_done longer than one cycle");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		int          err_before;
		int          n_pass;
		int          n_fail;
		rst_n      = 1'b0;
		cpu_bus    = '0;
		cpu_req    = 1'b0;
		page_wr    = 1'b0;
		video_req  = 1'b0;
		video_addr = VIDEO_ADDR;
		n_pass     = 0;
		n_fail     = 0;
		void'($urandom(32'h26a3));
		for (int i = 0; i < (1 << MEM_AW); i++)
		begin
			mem[i]    = dword_t'($urandom());
			mirror[i] = mem[i];
		end

		// window 1 read, page write, byte lanes, video priority, latency
		tests[0] = make_row(OP_READ,  16'h4022, 8'h00, 1'b0);
		tests[1] = make_row(OP_PAGE,  16'h8000, 8'h07, 1'b0);
		tests[2] = make_row(OP_READ,  16'h8a35, 8'h00, 1'b0);
		tests[3] = make_row(OP_WRITE, 16'h4123, 8'hc3, 1'b0);
		tests[4] = make_row(OP_READ,  16'h4123, 8'h00, 1'b0);
		tests[5] = make_row(OP_READ,  16'h4122, 8'h00, 1'b0);
		tests[6] = make_row(OP_READ,  16'h8a34, 8'h00, 1'b1);
		tests[7] = make_row(OP_WRITE, 16'hc010, 8'h5e, 1'b1);
		tests[8] = make_row(OP_READ,  16'h0005, 8'h00, 1'b0);
		build_expected();

		repeat (RESET_CYCLES) @(posedge fclk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		step_cycle();
		if (dram_req || cpu_done || cpu_busy)
			report_mismatch("dram_req, cpu_done or cpu_busy high after reset");

		for (int i = 0; i < NUM_ROWS; i++)
		begin
			err_before = errors;
			if (tests[i].op == OP_PAGE)
				run_page(tests[i]);
			else
				run_access(tests[i]);
			if (errors == err_before)
				n_pass++;
			else
				n_fail++;
			$display("test %0d %s za=%h video=%b: %s", i, op_label(tests[i].op),
				tests[i].za, tests[i].video, (errors == err_before) ? "ok" : "FAILED");
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			NUM_ROWS, n_pass, n_fail, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- zx_mem.f
src/zx_mem_pkg.sv
src/phase_counter.sv
src/window_pager.sv
src/cpu_port.sv
src/dram_arbiter.sv
src/zx_mem_top.sv
test/zx_mem_sva.sv
test/tb_zx_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
	--top-module tb_zx_mem_top -f zx_mem.f -o tb_zx_mem_top || exit 1
out=$(./obj_dir/tb_zx_mem_top)
echo "$out"
echo "$out" | grep -qxF '>>> PASS' && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
